/* Bender.yml */
package:
  name: reg_read_stage

sources:
  - logic/regReadPkg.sv
  - logic/operandDecode.sv
  - logic/physRegFile.sv
  - logic/operandSelect.sv
  - logic/issueResult.sv
  - logic/readyTable.sv
  - logic/regReadStage.sv
  - target: test
    files:
      - test/regReadTb.sv

/* flist.f */
logic/regReadPkg.sv
logic/operandDecode.sv
logic/physRegFile.sv
logic/operandSelect.sv
logic/issueResult.sv
logic/readyTable.sv
logic/regReadStage.sv
test/regReadTb.sv

/* logic/issueResult.sv */
// result stage with per-lane mispredict squash and the registered read packets
`timescale 1ns/100ps

module issueResult (
  input                                                          clk,
  input                                                          rstN_i,
  input  regReadPkg::issuePktT      [regReadPkg::numLanes-1:0]      issue_i,
  input  regReadPkg::branchResolveT                                 branch_i,
  input  regReadPkg::dataT          [regReadPkg::numLanes-1:0][1:0] operand_i,
  output regReadPkg::readPktT       [regReadPkg::numLanes-1:0]      read_o,
  output logic                      [regReadPkg::numLanes-1:0]      readValid_o
);

  import regReadPkg::*;

  logic                mispredictEvent;
  logic [numLanes-1:0] squash;

  assign mispredictEvent = branch_i.verified & branch_i.mispredict;

  // kill anything that sits under the mispredicted checkpoint
  always_comb begin
    for (int l = 0; l < numLanes; l++) begin
      squash[l] = mispredictEvent & issue_i[l].ckptMask[branch_i.ckpt];
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      readValid_o <= '0;
    end else begin
      for (int l = 0; l < numLanes; l++) begin
        readValid_o[l] <= issue_i[l].valid & ~squash[l];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int l = 0; l < numLanes; l++) begin
      read_o[l].ckptMask <= issue_i[l].ckptMask;
      read_o[l].payload  <= issue_i[l].payload;
      read_o[l].data1    <= operand_i[l][0];
      read_o[l].data2    <= operand_i[l][1];
    end
  end

  // packet under a resolved mispredict never leaves the stage
  for (genvar l = 0; l < numLanes; l++) begin : gSquashChk
    assert property (@(posedge clk) disable iff (!rstN_i)
      (branch_i.verified && branch_i.mispredict && issue_i[l].ckptMask[branch_i.ckpt])
        |=> !readValid_o[l])
      else $error("issueResult: lane %0d valid after squash", l);
  end

endmodule

/* logic/operandDecode.sv */
// decode stage: source tag extraction and bypass match vectors per operand
`timescale 1ns/100ps

module operandDecode (
  input  regReadPkg::issuePktT  [regReadPkg::numLanes-1:0]       issue_i,
  input  regReadPkg::bypassPktT [regReadPkg::numBypass-1:0]      bypass_i,
  output regReadPkg::physTagT   [regReadPkg::numLanes-1:0][1:0]  srcTag_o,
  output regReadPkg::matchVecT  [regReadPkg::numLanes-1:0][1:0]  matchVec_o
);

  import regReadPkg::*;

  physTagT [numLanes-1:0][1:0] srcTag;

  // operand 0 is src1, operand 1 is src2
  always_comb begin
    for (int l = 0; l < numLanes; l++) begin
      srcTag[l][0] = issue_i[l].src1;
      srcTag[l][1] = issue_i[l].src2;
    end
  end

  // one bit per bypass port whose dest hits the source tag
  always_comb begin
    for (int l = 0; l < numLanes; l++) begin
      for (int o = 0; o < 2; o++) begin
        for (int b = 0; b < numBypass; b++) begin
          matchVec_o[l][o][b] = bypass_i[b].valid && (bypass_i[b].dest == srcTag[l][o]);
        end
      end
    end
  end

  assign srcTag_o = srcTag;

endmodule

/* logic/operandSelect.sv */
// execute stage: per-operand choice between forwarded data and file data
`timescale 1ns/100ps

module operandSelect (
  input  regReadPkg::matchVecT  [regReadPkg::numLanes-1:0][1:0] matchVec_i,
  input  regReadPkg::bypassPktT [regReadPkg::numBypass-1:0]     bypass_i,
  input  regReadPkg::dataT      [regReadPkg::numLanes-1:0][1:0] fileData_i,
  output regReadPkg::dataT      [regReadPkg::numLanes-1:0][1:0] operand_o
);

  import regReadPkg::*;

  dataT [numLanes-1:0][1:0] operand;

  // a forwarded value always beats the file
  always_comb begin
    for (int l = 0; l < numLanes; l++) begin
      for (int o = 0; o < 2; o++) begin
        operand[l][o] = fileData_i[l][o];
        for (int b = 0; b < numBypass; b++) begin
          if (matchVec_i[l][o][b]) begin
            operand[l][o] = bypass_i[b].data;
          end
        end
      end
    end
  end

  assign operand_o = operand;

  // two ports carrying the same dest would make the pick ambiguous
  for (genvar l = 0; l < numLanes; l++) begin : gChk
    for (genvar o = 0; o < 2; o++) begin : gOp
      always_comb begin
        assert final ($onehot0(matchVec_i[l][o]))
          else $error("operandSelect: lane %0d src%0d match %b", l, o + 1, matchVec_i[l][o]);
      end
    end
  end

endmodule

/* logic/physRegFile.sv */
// physical register array: bypass-port writes gated by recovery, four async reads
`timescale 1ns/100ps

module physRegFile (
  input                                                        clk,
  input  regReadPkg::bypassPktT [regReadPkg::numBypass-1:0]     bypass_i,
  input                                                        recover_i,
  input  regReadPkg::physTagT   [regReadPkg::numLanes-1:0][1:0] srcTag_i,
  output regReadPkg::dataT      [regReadPkg::numLanes-1:0][1:0] fileData_o
);

  import regReadPkg::*;

  dataT                 regArray [numPhysRegs];
  logic [numBypass-1:0] wrEn;

  // forwarding still sees the data, only the file update is held off
  always_comb begin
    for (int b = 0; b < numBypass; b++) begin
      wrEn[b] = bypass_i[b].valid & ~recover_i;
    end
  end

  always_ff @(posedge clk) begin
    for (int b = 0; b < numBypass; b++) begin
      if (wrEn[b]) begin
        regArray[bypass_i[b].dest] <= bypass_i[b].data;
      end
    end
  end

  // reads return the value from before this cycle's write
  always_comb begin
    for (int l = 0; l < numLanes; l++) begin
      for (int o = 0; o < 2; o++) begin
        fileData_o[l][o] = regArray[srcTag_i[l][o]];
      end
    end
  end

  // a shared dest would leave the file and the forwarded value disagreeing
  for (genvar a = 0; a < numBypass; a++) begin : gWrChk
    for (genvar b = a + 1; b < numBypass; b++) begin : gPair
      assert property (@(posedge clk)
        !(wrEn[a] && wrEn[b] && (bypass_i[a].dest == bypass_i[b].dest)))
        else $error("physRegFile: ports %0d and %0d write tag %0d", a, b, bypass_i[a].dest);
    end
  end

endmodule

/* logic/readyTable.sv */
// physical register ready bits: arch pattern on reset or exception, unmap and wakeup
`timescale 1ns/100ps

module readyTable (
  input                                                   clk,
  input                                                   rstN_i,
  input                                                   exception_i,
  input  regReadPkg::unmapT   [regReadPkg::numLanes-1:0]  unmap_i,
  input  regReadPkg::physTagT [regReadPkg::numLanes-1:0]  wakeTag_i,
  input  logic                [regReadPkg::numLanes-1:0]  wakeValid_i,
  output regReadPkg::readyVecT                            phyRegRdy_o
);

  import regReadPkg::*;

  readyVecT rdyVec;
  readyVecT rdyNext;

  // clears first, sets after, so a wakeup wins over a same-tag unmap
  always_comb begin
    rdyNext = rdyVec;
    for (int l = 0; l < numLanes; l++) begin
      if (unmap_i[l].valid) begin
        rdyNext[unmap_i[l].tag] = 1'b0;
      end
    end
    for (int l = 0; l < numLanes; l++) begin
      if (wakeValid_i[l]) begin
        rdyNext[wakeTag_i[l]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i || exception_i) begin
      rdyVec <= archRdyVec; // committed map only
    end else begin
      rdyVec <= rdyNext;
    end
  end

  assign phyRegRdy_o = rdyVec;

endmodule

/* logic/regReadPkg.sv */
// register-read sizes, vector types and the issue, bypass, branch and read packets
package regReadPkg;

  localparam int numLanes       = 2;  // issue lanes
  localparam int numBypass      = 2;  // writeback ports
  localparam int numPhysRegs    = 64;
  localparam int physTagW       = 6;
  localparam int numArchRegs    = 32; // ready out of reset
  localparam int dataW          = 32;
  localparam int numCheckpoints = 4;
  localparam int ckptIdxW       = 2;
  localparam int payloadW       = 16; // opaque, passed through

  typedef logic [physTagW-1:0]       physTagT;
  typedef logic [dataW-1:0]          dataT;
  typedef logic [numCheckpoints-1:0] ckptMaskT;
  typedef logic [ckptIdxW-1:0]       ckptIdxT;
  typedef logic [payloadW-1:0]       payloadT;
  typedef logic [numBypass-1:0]      matchVecT;
  typedef logic [numPhysRegs-1:0]    readyVecT;

  // ready pattern loaded on reset and exception
  localparam readyVecT archRdyVec = readyVecT'({numArchRegs{1'b1}});

  typedef struct packed {
    logic     valid;
    ckptMaskT ckptMask; // branches this op depends on
    physTagT  src1;
    physTagT  src2;
    payloadT  payload;
  } issuePktT;

  typedef struct packed {
    logic    valid;
    physTagT dest;
    dataT    data;
  } bypassPktT;

  typedef struct packed {
    logic    verified;
    logic    mispredict;
    ckptIdxT ckpt; // checkpoint of the resolved branch
  } branchResolveT;

  typedef struct packed {
    logic    valid;
    physTagT tag;
  } unmapT;

  typedef struct packed {
    ckptMaskT ckptMask;
    payloadT  payload;
    dataT     data1;
    dataT     data2;
  } readPktT;

endpackage

/* logic/regReadStage.sv */
// register-read stage top: decode, register file, operand select, result and ready table
`timescale 1ns/100ps

module regReadStage (
  input                                                          clk,
  input                                                          rstN_i,
  input  regReadPkg::issuePktT      [regReadPkg::numLanes-1:0]   issue_i,
  input  regReadPkg::bypassPktT     [regReadPkg::numBypass-1:0]  bypass_i,
  input  regReadPkg::branchResolveT                              branch_i,
  input                                                          recover_i,
  input                                                          exception_i,
  input  regReadPkg::unmapT         [regReadPkg::numLanes-1:0]   unmap_i,
  input  regReadPkg::physTagT       [regReadPkg::numLanes-1:0]   wakeTag_i,
  input  logic                      [regReadPkg::numLanes-1:0]   wakeValid_i,
  output regReadPkg::readPktT       [regReadPkg::numLanes-1:0]   read_o,
  output logic                      [regReadPkg::numLanes-1:0]   readValid_o,
  output regReadPkg::readyVecT                                   phyRegRdy_o
);

  import regReadPkg::*;

  physTagT  [numLanes-1:0][1:0] srcTag;
  matchVecT [numLanes-1:0][1:0] matchVec;
  dataT     [numLanes-1:0][1:0] fileData;
  dataT     [numLanes-1:0][1:0] operand;

  operandDecode operandDecode_i (
    .issue_i    (issue_i),
    .bypass_i   (bypass_i),
    .srcTag_o   (srcTag),
    .matchVec_o (matchVec)
  );

  physRegFile physRegFile_i (
    .clk        (clk),
    .bypass_i   (bypass_i),
    .recover_i  (recover_i),
    .srcTag_i   (srcTag),
    .fileData_o (fileData)
  );

  operandSelect operandSelect_i (
    .matchVec_i (matchVec),
    .bypass_i   (bypass_i),
    .fileData_i (fileData),
    .operand_o  (operand)
  );

  // the only clocked stage on the issue path
  issueResult issueResult_i (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .issue_i     (issue_i),
    .branch_i    (branch_i),
    .operand_i   (operand),
    .read_o      (read_o),
    .readValid_o (readValid_o)
  );

  readyTable readyTable_i (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .exception_i (exception_i),
    .unmap_i     (unmap_i),
    .wakeTag_i   (wakeTag_i),
    .wakeValid_i (wakeValid_i),
    .phyRegRdy_o (phyRegRdy_o)
  );

endmodule

/* test/regReadTb.sv */
// testbench for the register-read stage: clock, reset, trace reader, stimulus, compare and report
`timescale 1ns/100ps

module regReadTb;

  import regReadPkg::*;

  localparam int numFields    = 36; // hex columns after the test name
  localparam int resetTimeout = 20;
  localparam int maxCycles    = 500;

  logic                         clk;
  logic                         rstN;
  issuePktT      [numLanes-1:0]  issue;
  bypassPktT     [numBypass-1:0] bypass;
  branchResolveT                 branch;
  logic                          recover;
  logic                          exception;
  unmapT         [numLanes-1:0]  unmap;
  physTagT       [numLanes-1:0]  wakeTag;
  logic          [numLanes-1:0]  wakeValid;
  readPktT       [numLanes-1:0]  readPkt;
  logic          [numLanes-1:0]  readValid;
  readyVecT                      phyRegRdy;

  int            fd;
  logic [63:0]   fld [numFields];
  string         curName;
  string         expName;
  string         runName;
  string         abortMsg;
  logic [3:0]    expChk;   // 1 valid, 2 lane0, 4 lane1, 8 ready
  logic [numLanes-1:0] expValid;
  dataT          expData [2*numLanes];
  readyVecT      expRdy;
  ckptMaskT      expMask [numLanes];
  payloadT       expPay [numLanes];
  int            testErrs;
  int            testsOk;
  int            testsFailed;

  regReadStage regReadStage_i (
    .clk         (clk),
    .rstN_i      (rstN),
    .issue_i     (issue),
    .bypass_i    (bypass),
    .branch_i    (branch),
    .recover_i   (recover),
    .exception_i (exception),
    .unmap_i     (unmap),
    .wakeTag_i   (wakeTag),
    .wakeValid_i (wakeValid),
    .read_o      (readPkt),
    .readValid_o (readValid),
    .phyRegRdy_o (phyRegRdy)
  );

  initial begin : clockGen
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : resetGen
    rstN = 1'b0;
    repeat (4) @(posedge clk);
    #2 rstN = 1'b1;
  end

  task automatic clearInputs();
    issue     = '0;
    bypass    = '0;
    branch    = '0;
    recover   = 1'b0;
    exception = 1'b0;
    unmap     = '0;
    wakeTag   = '0;
    wakeValid = '0;
  endtask

  task automatic compareVal(input string what, input logic [63:0] expV, input logic [63:0] actV);
    if (actV !== expV) begin
      $display("ERROR %s %s expected %h actual %h", expName, what, expV, actV);
      testErrs++;
    end
  endtask

  task automatic closeTest();
    if (runName != "") begin
      if (testErrs == 0) begin
        $display("%-10s ok", runName);
        testsOk++;
      end else begin
        $display("%-10s %0d mismatches", runName, testErrs);
        testsFailed++;
      end
    end
    testErrs = 0;
  endtask

  // skips comment lines, then takes a name and the hex columns
  task automatic readLine(output bit got);
    string            tok;
    logic [8*256-1:0] rest;
    int               r;
    int               n;
    got = 1'b0;
    r = $fscanf(fd, "%s", tok);
    while (r == 1 && tok[0] == "#") begin
      r = $fgets(rest, fd);
      r = $fscanf(fd, "%s", tok);
    end
    if (r == 1) begin
      n = 0;
      for (int k = 0; k < numFields; k++) begin
        n += $fscanf(fd, "%h", fld[k]);
      end
      if (n == numFields) begin
        curName = tok;
        got     = 1'b1;
      end else begin
        abortMsg = {"trace line of test ", tok, " has missing columns"};
      end
    end
  endtask

  task automatic applyInputs();
    for (int l = 0; l < numLanes; l++) begin
      issue[l].valid    = fld[l*5][0];
      issue[l].ckptMask = ckptMaskT'(fld[l*5+1]);
      issue[l].src1     = physTagT'(fld[l*5+2]);
      issue[l].src2     = physTagT'(fld[l*5+3]);
      issue[l].payload  = payloadT'(fld[l*5+4]);
      unmap[l].valid    = fld[21+l*2][0];
      unmap[l].tag      = physTagT'(fld[22+l*2]);
      wakeValid[l]      = fld[25+l*2][0];
      wakeTag[l]        = physTagT'(fld[26+l*2]);
      expMask[l]        = issue[l].ckptMask; // passes through untouched
      expPay[l]         = issue[l].payload;
    end
    for (int b = 0; b < numBypass; b++) begin
      bypass[b].valid = fld[10+b*3][0];
      bypass[b].dest  = physTagT'(fld[11+b*3]);
      bypass[b].data  = dataT'(fld[12+b*3]);
    end
    branch.verified   = fld[16][0];
    branch.mispredict = fld[17][0];
    branch.ckpt       = ckptIdxT'(fld[18]);
    recover           = fld[19][0];
    exception         = fld[20][0];
    expName           = curName;
    expChk            = fld[29][3:0];
    expValid          = fld[30][numLanes-1:0];
    for (int k = 0; k < 2*numLanes; k++) begin
      expData[k] = dataT'(fld[31+k]);
    end
    expRdy = readyVecT'(fld[35]);
  endtask

  task automatic checkOutputs();
    if (expName != runName) begin
      closeTest();
      runName = expName;
    end
    if (expChk[0]) begin
      compareVal("readValid", expValid, readValid);
    end
    for (int l = 0; l < numLanes; l++) begin
      if (expChk[1+l]) begin
        compareVal($sformatf("lane%0d ckptMask", l), expMask[l], readPkt[l].ckptMask);
        compareVal($sformatf("lane%0d payload", l), expPay[l], readPkt[l].payload);
        compareVal($sformatf("lane%0d data1", l), expData[l*2], readPkt[l].data1);
        compareVal($sformatf("lane%0d data2", l), expData[l*2+1], readPkt[l].data2);
      end
    end
    if (expChk[3]) begin
      compareVal("phyRegRdy", expRdy, phyRegRdy);
    end
  endtask

  // outputs of line N are checked 1 ns after the edge that ends it
  task automatic runTrace();
    bit got;
    bit pending;
    int cycles;
    got     = 1'b1;
    pending = 1'b0;
    cycles  = 0;
    while (abortMsg == "" && (got || pending)) begin
      @(posedge clk);
      #1;
      cycles++;
      if (pending) begin
        checkOutputs();
      end
      pending = 1'b0;
      #1;
      if (got) begin
        readLine(got);
        if (got) begin
          applyInputs();
          pending = 1'b1;
        end else begin
          clearInputs();
        end
      end
      if (cycles > maxCycles) begin
        abortMsg = "trace ran past the cycle limit";
      end
    end
    closeTest();
  endtask

  initial begin : mainFlow
    int waitCnt;
    clearInputs();
    fd = $fopen("test/regReadTrace.txt", "r");
    if (fd == 0) begin
      abortMsg = "trace file test/regReadTrace.txt could not be opened";
    end
    waitCnt = 0;
    while (abortMsg == "" && rstN !== 1'b1) begin
      @(posedge clk);
      waitCnt++;
      if (waitCnt > resetTimeout) begin
        abortMsg = "reset was not released in time";
      end
    end
    if (abortMsg == "") begin
      runTrace();
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (abortMsg != "") begin
      $display("%s", abortMsg);
    end
    $display("%0d tests ok, %0d tests with mismatches", testsOk, testsFailed);
    if (abortMsg == "" && testsFailed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* test/regReadTrace.txt */
# name | lane0 v mask src1 src2 pay | lane1 same | byp0 v dest data | byp1 same | br ver mis ckpt
# rec exc | unmap0 v tag | unmap1 | wake0 v tag | wake1 | chk vld d00 d01 d10 d11 rdy (next cycle)
# chk bits: 1 readValid, 2 lane0 packet, 4 lane1 packet, 8 ready table
wr_fill    0 0 00 00 0000  0 0 00 00 0000  1 01 11111111  1 02 22222222  0 0 0  0 0  0 00 0 00  0 00 0 00  9 0 0 0 0 0 ffffffff
wr_fill    0 0 00 00 0000  0 0 00 00 0000  1 03 33333333  1 04 44444444  0 0 0  0 0  0 00 0 00  0 00 0 00  9 0 0 0 0 0 ffffffff
wr_fill    0 0 00 00 0000  0 0 00 00 0000  1 28 a5a5a5a5  1 29 5a5a5a5a  0 0 0  0 0  0 00 0 00  0 00 0 00  9 0 0 0 0 0 ffffffff
# file reads of earlier writes
file_read  1 1 01 02 1234  1 2 03 04 abcd  0 00 0  0 00 0  0 0 0  0 0  0 00 0 00  0 00 0 00  f 3 11111111 22222222 33333333 44444444 ffffffff
file_read  1 0 28 29 0f0f  1 8 01 04 f0f0  0 00 0  0 00 0  0 0 0  0 0  0 00 0 00  0 00 0 00  f 3 a5a5a5a5 5a5a5a5a 11111111 44444444 ffffffff
# forwarding beats the file, per lane and operand
bypass     1 1 05 01 1111  1 3 06 05 2222  1 05 c0de0005  1 06 c0de0006  0 0 0  0 0  0 00 0 00  0 00 0 00  f 3 c0de0005 11111111 c0de0006 c0de0005 ffffffff
bypass     1 2 05 06 3333  1 4 02 07 4444  1 07 77777777  1 02 bbbbbbbb  0 0 0  0 0  0 00 0 00  0 00 0 00  f 3 c0de0005 c0de0006 bbbbbbbb 77777777 ffffffff
bypass     1 0 02 07 5555  0 0 00 00 0000  0 00 0  0 00 0  0 0 0  0 0  0 00 0 00  0 00 0 00  3 1 bbbbbbbb 77777777 0 0 ffffffff
dual_port  1 1 09 0a 6666  1 2 0a 09 7777  1 09 90909090  1 0a a0a0a0a0  0 0 0  0 0  0 00 0 00  0 00 0 00  f 3 90909090 a0a0a0a0 a0a0a0a0 90909090 ffffffff
dual_port  1 4 0a 09 8888  1 8 09 09 9999  0 00 0  0 00 0  0 0 0  0 0  0 00 0 00  0 00 0 00  f 3 a0a0a0a0 90909090 90909090 90909090 ffffffff
# recovery forwards but does not write the file
recover    1 1 01 03 aaaa  1 2 04 02 bbbb  1 01 deaddead  1 03 beefbeef  0 0 0  1 0  0 00 0 00  0 00 0 00  f 3 deaddead beefbeef 44444444 bbbbbbbb ffffffff
recover    1 1 01 03 cccc  1 2 02 04 dddd  0 00 0  0 00 0  0 0 0  0 0  0 00 0 00  0 00 0 00  f 3 11111111 33333333 bbbbbbbb 44444444 ffffffff
recover    0 0 00 00 0000  0 0 00 00 0000  1 04 12345678  0 00 0  0 0 0  1 0  0 00 0 00  0 00 0 00  1 0 0 0 0 0 ffffffff
recover    1 0 04 04 eeee  0 0 00 00 0000  0 00 0  0 00 0  0 0 0  0 0  0 00 0 00  0 00 0 00  3 1 44444444 44444444 0 0 ffffffff
# squash needs verified, mispredict and the mask bit
squash     1 4 03 04 0001  1 3 01 02 0002  0 00 0  0 00 0  1 1 2  0 0  0 00 0 00  0 00 0 00  5 2 0 0 11111111 bbbbbbbb ffffffff
squash     1 4 03 04 0003  1 4 01 02 0004  0 00 0  0 00 0  1 0 2  0 0  0 00 0 00  0 00 0 00  f 3 33333333 44444444 11111111 bbbbbbbb ffffffff
squash     1 4 03 04 0003  1 4 01 02 0004  0 00 0  0 00 0  0 1 2  0 0  0 00 0 00  0 00 0 00  1 3 0 0 0 0 ffffffff
squash     1 e 03 04 0005  1 1 01 02 0006  0 00 0  0 00 0  1 1 0  0 0  0 00 0 00  0 00 0 00  3 1 33333333 44444444 0 0 ffffffff
squash     1 8 03 04 0007  1 f 01 02 0008  0 00 0  0 00 0  1 1 3  0 0  0 00 0 00  0 00 0 00  1 0 0 0 0 0 ffffffff
# ready table unmap, wakeup and exception
ready      0 0 00 00 0000  0 0 00 00 0000  0 00 0  0 00 0  0 0 0  0 0  1 05 1 21  1 28 0 00  8 0 0 0 0 0 100ffffffdf
ready      0 0 00 00 0000  0 0 00 00 0000  0 00 0  0 00 0  0 0 0  0 0  0 00 1 28  1 05 0 00  8 0 0 0 0 0 ffffffff
ready      0 0 00 00 0000  0 0 00 00 0000  0 00 0  0 00 0  0 0 0  0 0  1 0a 1 0b  1 3f 1 0a  8 0 0 0 0 0 80000000fffff7ff
ready      0 0 00 00 0000  0 0 00 00 0000  0 00 0  0 00 0  0 0 0  0 1  0 00 0 00  1 30 0 00  8 0 0 0 0 0 ffffffff
ready      0 0 00 00 0000  0 0 00 00 0000  0 00 0  0 00 0  0 0 0  0 0  0 00 0 00  0 00 0 00  9 0 0 0 0 0 ffffffff
